/* common/mipsPkg.sv */
package mipsPkg;

   // Datapath word and register index
   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;

   // Instruction fields
   typedef logic [5:0] opcodeT;
   typedef logic [5:0] functT;

   typedef enum logic [3:0] {
      aluAddu, aluSubu, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOpT;

   // Primary opcodes
   localparam opcodeT opRType = 6'h00;
   localparam opcodeT opJ     = 6'h02;
   localparam opcodeT opJal   = 6'h03;
   localparam opcodeT opBeq   = 6'h04;
   localparam opcodeT opBne   = 6'h05;
   localparam opcodeT opAddiu = 6'h09;
   localparam opcodeT opSlti  = 6'h0a;
   localparam opcodeT opSltiu = 6'h0b;
   localparam opcodeT opAndi  = 6'h0c;
   localparam opcodeT opOri   = 6'h0d;
   localparam opcodeT opXori  = 6'h0e;
   localparam opcodeT opLui   = 6'h0f;
   localparam opcodeT opLw    = 6'h23;
   localparam opcodeT opSw    = 6'h2b;

   // R-type funct codes
   localparam functT functSll  = 6'h00;
   localparam functT functSrl  = 6'h02;
   localparam functT functSra  = 6'h03;
   localparam functT functSllv = 6'h04;
   localparam functT functSrlv = 6'h06;
   localparam functT functSrav = 6'h07;
   localparam functT functJr   = 6'h08;
   localparam functT functJalr = 6'h09;
   localparam functT functAddu = 6'h21;
   localparam functT functSubu = 6'h23;
   localparam functT functAnd  = 6'h24;
   localparam functT functOr   = 6'h25;
   localparam functT functXor  = 6'h26;
   localparam functT functNor  = 6'h27;
   localparam functT functSlt  = 6'h2a;
   localparam functT functSltu = 6'h2b;

   // Jal destination and return offset past the delay slot
   localparam regAddrT linkReg    = 5'd31;
   localparam wordT    linkOffset = 32'd8;

   // Control carried from decode into execute
   typedef struct packed {
      aluOpT aluOp;
      logic  regWrite;
      logic  aluSrcImm;
      logic  regDstRd;
      logic  shiftImm;
      logic  memRead;
      logic  memWrite;
      logic  branchEq;
      logic  branchNe;
      logic  jump;
      logic  jumpReg;
      logic  link;
   } ctrlT;

endpackage

/* common/writebackIf.sv */
`timescale 1ns/10ps

// Register write port from memory stage, seen by decode and execute
interface writebackIf import mipsPkg::*; (
   input logic clk
);

   logic    regWrite;
   regAddrT writeAddr;
   wordT    writeData;

   // A write counts only with a nonzero address
   modport source (
      input  clk,
      output regWrite,
      output writeAddr,
      output writeData
   );

   modport sink (
      input clk,
      input regWrite,
      input writeAddr,
      input writeData
   );

endinterface

/* datapath/alu.sv */
`timescale 1ns/10ps

module alu import mipsPkg::*; (
   input  wordT  a,
   input  wordT  b,
   input  aluOpT op,
   output wordT  result
);

   // Shift distance from low bits of a
   logic [4:0] shiftAmt;

   assign shiftAmt = a[4:0];

   always_comb begin
      case (op)
         aluAddu: result = a + b;
         aluSubu: result = a - b;
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluXor:  result = a ^ b;
         aluNor:  result = ~(a | b);
         aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
         aluSltu: result = {31'd0, a < b};
         // Shifted value always comes from b
         aluSll:  result = b << shiftAmt;
         aluSrl:  result = b >> shiftAmt;
         aluSra:  result = $signed(b) >>> shiftAmt;
         // Upper immediate
         aluLui:  result = {b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

endmodule

/* datapath/regFile.sv */
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
   input  logic     clk,
   input  regAddrT  readAddrA,
   input  regAddrT  readAddrB,
   output wordT     readDataA,
   output wordT     readDataB,
   writebackIf.sink wb
);

   wordT regs [32];

   // Writes to register 0 are dropped
   always_ff @(posedge clk) begin
      if (wb.regWrite && wb.writeAddr != '0) begin
         regs[wb.writeAddr] <= wb.writeData;
      end
   end

   // Asynchronous read, r0 hardwired
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* datapath/controlDecoder.sv */
`timescale 1ns/10ps

module controlDecoder import mipsPkg::*; (
   input  opcodeT opcode,
   input  functT  funct,
   output aluOpT  aluOp,
   output logic   regWrite,
   output logic   signExtend,
   output logic   aluSrcImm,
   output logic   regDstRd,
   output logic   shiftImm,
   output logic   memRead,
   output logic   memWrite,
   output logic   branchEq,
   output logic   branchNe,
   output logic   jump,
   output logic   jumpReg,
   output logic   link
);

   always_comb begin
      // Unknown encodings fall through as a nop
      aluOp      = aluAddu;
      regWrite   = 1'b0;
      signExtend = 1'b0;
      aluSrcImm  = 1'b0;
      regDstRd   = 1'b0;
      shiftImm   = 1'b0;
      memRead    = 1'b0;
      memWrite   = 1'b0;
      branchEq   = 1'b0;
      branchNe   = 1'b0;
      jump       = 1'b0;
      jumpReg    = 1'b0;
      link       = 1'b0;
      case (opcode)
         opRType: begin
            regDstRd = 1'b1;
            regWrite = 1'b1;
            case (funct)
               functSll:  begin aluOp = aluSll; shiftImm = 1'b1; end
               functSrl:  begin aluOp = aluSrl; shiftImm = 1'b1; end
               functSra:  begin aluOp = aluSra; shiftImm = 1'b1; end
               functSllv: aluOp = aluSll;
               functSrlv: aluOp = aluSrl;
               functSrav: aluOp = aluSra;
               functAddu: aluOp = aluAddu;
               functSubu: aluOp = aluSubu;
               functAnd:  aluOp = aluAnd;
               functOr:   aluOp = aluOr;
               functXor:  aluOp = aluXor;
               functNor:  aluOp = aluNor;
               functSlt:  aluOp = aluSlt;
               functSltu: aluOp = aluSltu;
               // Jr writes nothing
               functJr:   begin jumpReg = 1'b1; regWrite = 1'b0; end
               functJalr: begin jumpReg = 1'b1; link = 1'b1; end
               default:   regWrite = 1'b0;
            endcase
         end
         // Immediate ALU ops, logical ones zero extend
         opAddiu: begin aluSrcImm = 1'b1; signExtend = 1'b1; regWrite = 1'b1; end
         opSlti:  begin
            aluOp = aluSlt; aluSrcImm = 1'b1; signExtend = 1'b1; regWrite = 1'b1;
         end
         opSltiu: begin
            aluOp = aluSltu; aluSrcImm = 1'b1; signExtend = 1'b1; regWrite = 1'b1;
         end
         opAndi:  begin aluOp = aluAnd; aluSrcImm = 1'b1; regWrite = 1'b1; end
         opOri:   begin aluOp = aluOr; aluSrcImm = 1'b1; regWrite = 1'b1; end
         opXori:  begin aluOp = aluXor; aluSrcImm = 1'b1; regWrite = 1'b1; end
         opLui:   begin aluOp = aluLui; aluSrcImm = 1'b1; regWrite = 1'b1; end
         // Word memory access, address is rs plus offset
         opLw: begin
            aluSrcImm = 1'b1; signExtend = 1'b1; memRead = 1'b1; regWrite = 1'b1;
         end
         opSw:  begin aluSrcImm = 1'b1; signExtend = 1'b1; memWrite = 1'b1; end
         opBeq: begin branchEq = 1'b1; signExtend = 1'b1; end
         opBne: begin branchNe = 1'b1; signExtend = 1'b1; end
         opJ:   jump = 1'b1;
         opJal: begin jump = 1'b1; link = 1'b1; regWrite = 1'b1; end
         default: ;
      endcase
   end

endmodule

/* datapath/fetchDecode.sv */
`timescale 1ns/10ps

module fetchDecode import mipsPkg::*; #(
   parameter wordT resetVector = 32'h4000_0000
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        stall,
   input  wordT        instruction,
   output wordT        instrAddr,
   input  logic        redirect,
   input  wordT        redirectPc,
   writebackIf.sink    wb,
   output ctrlT        ctrlE,
   output wordT        rsDataE,
   output wordT        rtDataE,
   output wordT        immE,
   output wordT        shamtE,
   output wordT        pcE,
   output regAddrT     rsE,
   output regAddrT     rtE,
   output regAddrT     rdE,
   output logic [25:0] targetE
);

   // PC of the word now in decode
   wordT pc;
   wordT nextPc;
   // Next PC saved alongside the instruction in execute
   wordT nextPcE;
   // Low for the first cycle after reset
   logic validF;

   // Raw instruction fields
   regAddrT     rs;
   regAddrT     rt;
   logic [15:0] imm;

   // Decoder outputs
   aluOpT aluOp;
   logic  regWrite, signExtend, aluSrcImm, regDstRd, shiftImm;
   logic  memRead, memWrite, branchEq, branchNe, jump, jumpReg, link;
   ctrlT  ctrlF;

   wordT readDataA;
   wordT readDataB;
   wordT rsData;
   wordT rtData;
   wordT immExt;

   assign rs  = instruction[25:21];
   assign rt  = instruction[20:16];
   assign imm = instruction[15:0];

   // Hold fetch at the reset vector through the squash cycle
   assign nextPc = !validF ? pc : (redirect ? redirectPc : pc + 32'd4);
   // Re-read the held word while stalled
   assign instrAddr = stall ? nextPcE : nextPc;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= resetVector;
         validF <= 1'b0;
      end else if (!stall) begin
         pc     <= nextPc;
         validF <= 1'b1;
      end
   end

   controlDecoder controlDecoderInst (
      .opcode(instruction[31:26]),
      .funct(instruction[5:0]),
      .aluOp(aluOp),
      .regWrite(regWrite),
      .signExtend(signExtend),
      .aluSrcImm(aluSrcImm),
      .regDstRd(regDstRd),
      .shiftImm(shiftImm),
      .memRead(memRead),
      .memWrite(memWrite),
      .branchEq(branchEq),
      .branchNe(branchNe),
      .jump(jump),
      .jumpReg(jumpReg),
      .link(link)
   );

   assign ctrlF = '{aluOp, regWrite, aluSrcImm, regDstRd, shiftImm, memRead,
                    memWrite, branchEq, branchNe, jump, jumpReg, link};

   assign immExt = signExtend ? {{16{imm[15]}}, imm} : {16'h0000, imm};

   regFile regFileInst (
      .clk(clk),
      .readAddrA(rs),
      .readAddrB(rt),
      .readDataA(readDataA),
      .readDataB(readDataB),
      .wb(wb)
   );

   // Same-cycle write bypass
   assign rsData = (wb.regWrite && wb.writeAddr != '0 && wb.writeAddr == rs) ?
                   wb.writeData : readDataA;
   assign rtData = (wb.regWrite && wb.writeAddr != '0 && wb.writeAddr == rt) ?
                   wb.writeData : readDataB;

   // F/E control
   always_ff @(posedge clk) begin
      if (reset) begin
         ctrlE <= '0;
      end else if (!stall) begin
         ctrlE <= validF ? ctrlF : '0;
      end
   end

   // F/E payload
   always_ff @(posedge clk) begin
      if (!stall) begin
         rsDataE <= rsData;
         rtDataE <= rtData;
         immE    <= immExt;
         shamtE  <= {27'd0, instruction[10:6]};
         pcE     <= pc;
         nextPcE <= nextPc;
         rsE     <= rs;
         rtE     <= rt;
         rdE     <= instruction[15:11];
         targetE <= instruction[25:0];
      end
   end

endmodule

/* datapath/executeMem.sv */
`timescale 1ns/10ps

module executeMem import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        stall,
   input  ctrlT        ctrlE,
   input  wordT        rsDataE,
   input  wordT        rtDataE,
   input  wordT        immE,
   input  wordT        shamtE,
   input  wordT        pcE,
   input  regAddrT     rsE,
   input  regAddrT     rtE,
   input  regAddrT     rdE,
   input  logic [25:0] targetE,
   output logic        redirect,
   output wordT        redirectPc,
   output wordT        dataAddr,
   output wordT        dataWriteData,
   output logic        dataWrite,
   input  wordT        dataReadData,
   writebackIf.source  wb
);

   wordT    rsFwd, rtFwd;
   wordT    aluA, aluB, aluResult;
   // Delay-slot PC
   wordT    slotPc;
   wordT    branchTarget, jumpAddr;
   logic    branchTaken;
   regAddrT destE;

   // E/M register
   logic    regWriteM, memReadM, linkM;
   wordT    aluM, pcM;
   regAddrT writeAddrM;

   // Forward from memory stage, load data included
   assign rsFwd = (wb.regWrite && wb.writeAddr != '0 && wb.writeAddr == rsE) ?
                  wb.writeData : rsDataE;
   assign rtFwd = (wb.regWrite && wb.writeAddr != '0 && wb.writeAddr == rtE) ?
                  wb.writeData : rtDataE;

   assign aluA = ctrlE.shiftImm ? shamtE : rsFwd;
   assign aluB = ctrlE.aluSrcImm ? immE : rtFwd;

   alu aluInst (
      .a(aluA),
      .b(aluB),
      .op(ctrlE.aluOp),
      .result(aluResult)
   );

   // Branch and jump resolution
   assign slotPc       = pcE + 32'd4;
   assign branchTarget = slotPc + {immE[29:0], 2'b00};
   assign jumpAddr     = {slotPc[31:28], targetE, 2'b00};
   assign branchTaken  = (ctrlE.branchEq && rsFwd == rtFwd) ||
                         (ctrlE.branchNe && rsFwd != rtFwd);
   assign redirect     = branchTaken || ctrlE.jump || ctrlE.jumpReg;
   assign redirectPc   = ctrlE.jumpReg ? rsFwd : (ctrlE.jump ? jumpAddr : branchTarget);

   // Memory stage address re-presented while stalled
   assign dataAddr      = stall ? aluM : aluResult;
   assign dataWriteData = rtFwd;
   assign dataWrite     = ctrlE.memWrite && !stall;

   // Jal targets r31, jalr and R-type use rd
   assign destE = (ctrlE.link && !ctrlE.regDstRd) ? linkReg :
                  (ctrlE.regDstRd ? rdE : rtE);

   always_ff @(posedge clk) begin
      if (reset) begin
         regWriteM <= 1'b0;
         memReadM  <= 1'b0;
         linkM     <= 1'b0;
      end else if (!stall) begin
         regWriteM <= ctrlE.regWrite;
         memReadM  <= ctrlE.memRead;
         linkM     <= ctrlE.link;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         aluM       <= aluResult;
         pcM        <= pcE;
         writeAddrM <= destE;
      end
   end

   // Writeback, held off while stalled
   assign wb.regWrite  = regWriteM && !stall;
   assign wb.writeAddr = writeAddrM;
   assign wb.writeData = memReadM ? dataReadData : (linkM ? pcM + linkOffset : aluM);

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; #(
   parameter wordT resetVector = 32'h4000_0000
) (
   input  logic clk,
   input  logic reset,
   input  logic stall,
   output wordT instrAddr,
   input  wordT instruction,
   output wordT dataAddr,
   output logic dataWrite,
   output wordT dataWriteData,
   input  wordT dataReadData
);

   // F/E register outputs
   ctrlT        ctrlE;
   wordT        rsDataE;
   wordT        rtDataE;
   wordT        immE;
   wordT        shamtE;
   wordT        pcE;
   regAddrT     rsE;
   regAddrT     rtE;
   regAddrT     rdE;
   logic [25:0] targetE;

   // Branch and jump resolution back to fetch
   logic redirect;
   wordT redirectPc;

   writebackIf wbBus (.clk(clk));

   fetchDecode #(
      .resetVector(resetVector)
   ) fetchDecodeInst (
      .clk(clk),
      .reset(reset),
      .stall(stall),
      .instruction(instruction),
      .instrAddr(instrAddr),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .wb(wbBus.sink),
      .ctrlE(ctrlE),
      .rsDataE(rsDataE),
      .rtDataE(rtDataE),
      .immE(immE),
      .shamtE(shamtE),
      .pcE(pcE),
      .rsE(rsE),
      .rtE(rtE),
      .rdE(rdE),
      .targetE(targetE)
   );

   executeMem executeMemInst (
      .clk(clk),
      .reset(reset),
      .stall(stall),
      .ctrlE(ctrlE),
      .rsDataE(rsDataE),
      .rtDataE(rtDataE),
      .immE(immE),
      .shamtE(shamtE),
      .pcE(pcE),
      .rsE(rsE),
      .rtE(rtE),
      .rdE(rdE),
      .targetE(targetE),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .dataAddr(dataAddr),
      .dataWriteData(dataWriteData),
      .dataWrite(dataWrite),
      .dataReadData(dataReadData),
      .wb(wbBus.source)
   );

endmodule

/* bench/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*;;

   localparam wordT resetVector = 32'h4000_0000;
   localparam int   memWords    = 256;
   localparam int   settleCycles = 20;

   logic clk;
   logic reset;
   logic stall;
   wordT instrAddr;
   wordT instruction;
   wordT dataAddr;
   logic dataWrite;
   wordT dataWriteData;
   wordT dataReadData;

   // Word-indexed memory models
   wordT imem [memWords];
   wordT dmem [memWords];
   // Addresses captured on the rising edge
   wordT fetchAddrQ;
   wordT readAddrQ;

   // Expected store records in program order
   wordT expAddr [$];
   wordT expData [$];
   int   numI;
   int   storeIdx;
   int   runLimit;
   logic loaded;
   string runName;

   mipsCore #(
      .resetVector(resetVector)
   ) dut (
      .clk(clk),
      .reset(reset),
      .stall(stall),
      .instrAddr(instrAddr),
      .instruction(instruction),
      .dataAddr(dataAddr),
      .dataWrite(dataWrite),
      .dataWriteData(dataWriteData),
      .dataReadData(dataReadData)
   );

   always #10 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input wordT expected, input wordT actual);
      if (expected !== actual) begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         failRun("value mismatch");
      end
   endtask

   // Read I and S records from the vectors file
   task automatic loadVectors();
      int    fd;
      int    count;
      string line;
      byte   kind;
      wordT  addr;
      wordT  data;
      fd = $fopen("bench/mipsCoreVectors.txt", "r");
      if (fd == 0) begin
         failRun("cannot open bench/mipsCoreVectors.txt");
      end
      numI = 0;
      for (int i = 0; i < memWords; i++) begin
         imem[i] = '0;
      end
      while ($fgets(line, fd) > 0) begin
         count = $sscanf(line, "%c %h %h", kind, addr, data);
         if (count == 3 && kind == "I") begin
            imem[addr[9:2]] = data;
            numI++;
         end else if (count == 3 && kind == "S") begin
            expAddr.push_back(addr);
            expData.push_back(data);
         end
      end
      $fclose(fd);
      // Budget per run doubled for random stall
      runLimit = numI * 40 * 2;
   endtask

   // Synchronous-read memories drive their outputs on the falling edge
   always @(posedge clk) begin
      fetchAddrQ <= instrAddr;
      readAddrQ  <= dataAddr;
   end

   always @(negedge clk) begin
      instruction  = imem[fetchAddrQ[9:2]];
      dataReadData = dmem[readAddrQ[9:2]];
   end

   // Every store checked against the next S record
   always @(posedge clk) begin
      if (dataWrite) begin
         if (storeIdx >= expAddr.size()) begin
            failRun($sformatf("%s: surplus store to %h", runName, dataAddr));
         end else begin
            checkValue($sformatf("%s store %0d address", runName, storeIdx),
                       expAddr[storeIdx], dataAddr);
            checkValue($sformatf("%s store %0d data", runName, storeIdx),
                       expData[storeIdx], dataWriteData);
            dmem[dataAddr[9:2]] <= dataWriteData;
            storeIdx <= storeIdx + 1;
         end
      end
   end

   task automatic runProgram(input bit withStall, input string name);
      int cycles;
      runName  = name;
      stall    = 1'b0;
      reset    = 1'b1;
      storeIdx = 0;
      for (int i = 0; i < memWords; i++) begin
         dmem[i] = '0;
      end
      repeat (3) @(negedge clk);
      reset = 1'b0;
      // Fetch starts at the reset vector
      checkValue({name, " reset vector"}, resetVector, instrAddr);
      cycles = 0;
      while (storeIdx < expAddr.size() && cycles < runLimit) begin
         @(negedge clk);
         // A few clean cycles first and then stall about one in four
         stall = withStall && cycles > 2 && ($urandom % 4 == 0);
         cycles++;
      end
      stall = 1'b0;
      if (storeIdx < expAddr.size()) begin
         failRun($sformatf("%s: missing store, only %0d of %0d seen",
                           name, storeIdx, expAddr.size()));
      end
      // Program parks in a loop so any later store is surplus
      repeat (settleCycles) @(negedge clk);
   endtask

   // Watchdog over both runs
   initial begin
      wait (loaded === 1'b1);
      repeat (2 * runLimit + 4 * settleCycles) @(posedge clk);
      failRun("watchdog expired, simulation took too long");
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      stall        = 1'b0;
      instruction  = '0;
      dataReadData = '0;
      fetchAddrQ   = '0;
      readAddrQ    = '0;
      storeIdx     = 0;
      loaded       = 1'b0;
      runName      = "setup";
      void'($urandom(32'haf57_fb93));
      loadVectors();
      loaded = 1'b1;
      runProgram(1'b0, "plain run");
      runProgram(1'b1, "stall run");
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* mipsCore.f */
common/mipsPkg.sv
common/writebackIf.sv
datapath/alu.sv
datapath/regFile.sv
datapath/controlDecoder.sv
datapath/fetchDecode.sv
datapath/executeMem.sv
hw/mipsCore.sv
bench/mipsCoreTb.sv

/* bench/mipsCoreVectors.txt */
# I <instruction address> <instruction word>
# S <store address> <store data>, in program order
I 40000000 3C011234
I 40000004 34215678
I 40000008 AC010000
I 4000000C 2402FFFD
I 40000010 AC020004
I 40000014 00221821
I 40000018 00222023
I 4000001C AC030008
I 40000020 AC04000C
I 40000024 00222824
I 40000028 00203027
I 4000002C AC050010
I 40000030 AC060014
I 40000034 0041382A
I 40000038 0041402B
I 4000003C AC070018
I 40000040 AC08001C
I 40000044 00024843
I 40000048 00065102
I 4000004C AC090020
I 40000050 AC0A0024
I 40000054 00E15804
I 40000058 284CFFFE
I 4000005C AC0B0028
I 40000060 AC0C002C
I 40000064 304DFF00
I 40000068 382EFFFF
I 4000006C AC0D0030
I 40000070 AC0E0034
I 40000074 8C0F0004
I 40000078 25F00005
I 4000007C AC100038
I 40000080 8C110000
I 40000084 AC11003C
I 40000088 10250002
I 4000008C AC070040
I 40000090 AC080044
I 40000094 14250001
I 40000098 AC070048
I 4000009C AC10004C
I 400000A0 14070002
I 400000A4 AC100050
I 400000A8 AC010054
I 400000AC 0800002E
I 400000B0 AC090058
I 400000B4 AC01005C
I 400000B8 0C000033
I 400000BC AC070060
I 400000C0 AC1F0064
I 400000C4 08000036
I 400000CC 03E00008
I 400000D0 AC100068
I 400000D4 AC01006C
I 400000D8 3C124000
I 400000DC 365200F4
I 400000E0 0240A009
I 400000E4 AC070070
I 400000E8 AC140074
I 400000EC 0800003F
I 400000F4 02800008
I 400000F8 AC0A0078
I 400000FC 0800003F
S 00000000 12345678
S 00000004 FFFFFFFD
S 00000008 12345675
S 0000000C 1234567B
S 00000010 12345678
S 00000014 EDCBA987
S 00000018 00000001
S 0000001C 00000000
S 00000020 FFFFFFFE
S 00000024 0EDCBA98
S 00000028 2468ACF0
S 0000002C 00000001
S 00000030 0000FF00
S 00000034 1234A987
S 00000038 00000002
S 0000003C 12345678
S 00000040 00000001
S 00000048 00000001
S 0000004C 00000002
S 00000050 00000002
S 00000058 FFFFFFFE
S 00000060 00000001
S 00000068 00000002
S 00000064 400000C0
S 00000070 00000001
S 00000078 0EDCBA98
S 00000074 400000E8
